// ==== tests/avg_patterns.txt ====
// per test: cnt (last pass index) and frame length, then (cnt+1)*length samples,
// then length expected sums; 32-bit hex two's complement, frame length 0 ends the list
// test 0: two frames, summed
00000001 00000004
00000064
ffffffce
00001fff
ffffe000
00000017
fffffff9
00001fff
ffffe000
0000007b
ffffffc7
00003ffe
ffffc000
// test 1: cnt 0, frame passes through
00000000 00000004
00000001
ffffffff
0000012c
fffff060
00000001
ffffffff
0000012c
fffff060
// test 2: three frames, cleared once mid sequence
00000002 00000004
0000000a
00000014
ffffffe2
00001388
fffffffd
00000028
ffffffe2
00001388
00000007
ffffff9c
000003e8
00001388
0000000e
ffffffd8
000003ac
00003a98
// end
00000000 00000000

// ==== build.f ====
+incdir+hw
hw/avg_pkg.sv
hw/avg_stream_fifo.sv
hw/avg_accum.sv
hw/avg_regs.sv
hw/avg_top.sv
tests/avg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the averager testbench with Verilator, status follows the log
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module avg_tb -o avg_sim \
  && ./obj_dir/avg_sim | tee sim.log \
  || { echo "build or run error"; exit 1; }
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no result in log"; exit 1; }
echo "PASS"

// ==== tests/avg_tb.sv ====
// testbench for avg_top, stimulus and expected sums come from tests/avg_patterns.txt
// run from the project root so the pattern path resolves
// pattern frames must respect the 4..AVG_AMS sample limit of the DUT
`timescale 1ns/1ns
`include "avg_consts.svh"

module avg_tb import avg_pkg::*; ();

  localparam int PAT_WORDS = 128;
  localparam int TMO       = 200;  // cycles per wait loop

  logic         clk;
  logic         rst;
  sample_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  sum_beat_t    out_beat;
  logic         out_valid;
  logic         out_ready;
  apb_req_t     apb;
  apb_rsp_t     rsp;

  logic [31:0]  pat [PAT_WORDS];   // pattern words, see file comments
  int           checks     = 0;
  int           mismatches = 0;
  int           failures   = 0;    // timeouts and missing responses

  avg_top uut (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .apb       (apb),
    .rsp       (rsp)
  );

  always #4 clk = ~clk;  // 8 ns

  ////////////////////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      $display("MISMATCH t=%0t %s expected %08h actual %08h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      failures++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB host
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [11:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    apb.psel    = 1'b1;  // setup
    apb.penable = 1'b0;
    apb.pwrite  = wr;
    apb.paddr   = adr;
    apb.pwdata  = wdat;
    @(posedge clk);
    #1;
    apb.penable = 1'b1;  // access, held until pready
    @(negedge clk);
    while (!rsp.pready && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (!rsp.pready) begin
      $display("ERROR t=%0t APB access to %03h never completed", $time, adr);
      failures++;
    end
    rdat = rsp.prdata;
    err  = rsp.pslverr;
    @(posedge clk);
    #1;
    apb = '0;
  endtask

  task automatic apb_write(input logic [11:0] adr, input logic [31:0] wdat);
    logic [31:0] rdat;
    logic        err;
    apb_access(1'b1, adr, wdat, rdat, err);
    compare("pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic apb_read(input logic [11:0] adr, output logic [31:0] rdat);
    logic err;
    apb_access(1'b0, adr, 32'd0, rdat, err);
    compare("pslverr", 32'd0, {31'd0, err});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // streams
  ////////////////////////////////////////////////////////////////////////////

  // nothing drains the input FIFO while run is low so it fills up
  task automatic fill_input_fifo();
    int i;
    for (i = 0; i < `AVG_FIFO_DEPTH; i++) begin
      @(posedge clk);
      #1;
      in_valid     = 1'b1;
      in_beat.data = `AVG_IDW'(i);
      in_beat.last = 1'b0;
      @(negedge clk);
      expect_true(in_ready, "in_ready low before the input FIFO was full");
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    @(negedge clk);
    compare("in_ready", 32'd0, {31'd0, in_ready});  // full
  endtask

  // n samples from pat[base], last on every len-th beat
  task automatic send_frames(input int base, input int n, input int len, input bit gaps);
    int idx;
    int stall;
    idx   = 0;
    stall = 0;
    while (idx < n && stall < TMO) begin
      @(posedge clk);
      #1;
      in_valid     = !gaps || ($urandom % 4 != 0);  // random idle beats
      in_beat.data = pat[base + idx][`AVG_IDW-1:0];
      in_beat.last = (idx % len) == (len - 1);
      @(negedge clk);
      if (in_valid && in_ready) begin
        idx++;  // transfers on the coming edge
        stall = 0;
      end else begin
        stall++;
      end
    end
    if (idx < n) begin
      $display("ERROR t=%0t input stalled after %0d of %0d samples", $time, idx, n);
      failures++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic collect_sums(input int ebase, input int len, input bit gaps);
    int          k;
    int          stall;
    logic [31:0] got;
    k     = 0;
    stall = 0;
    while (k < len && stall < TMO) begin
      @(posedge clk);
      #1;
      out_ready = !gaps || ($urandom % 3 != 0);  // back-pressure
      @(negedge clk);
      if (out_valid && out_ready) begin
        got = {{(32 - `AVG_ODW){out_beat.data[`AVG_ODW-1]}}, out_beat.data};
        compare("out_beat.data", pat[ebase + k], got);
        compare("out_beat.last", {31'd0, (k == len - 1)}, {31'd0, out_beat.last});
        k++;
        stall = 0;
      end else begin
        stall++;
      end
    end
    if (k < len) begin
      $display("ERROR t=%0t only %0d of %0d sums came out", $time, k, len);
      failures++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one pattern test: setup, optional mid clear, stream, status, readback
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int base, input bit gaps, input bit mid_clear, output int next);
    int          cnt;
    int          len;
    int          nsmp;
    int          ebase;
    int          k;
    logic [31:0] rd;
    logic [31:0] seq0;
    cnt   = pat[base];
    len   = pat[base + 1];
    nsmp  = (cnt + 1) * len;
    ebase = base + 2 + nsmp;  // expected sums follow the samples
    next  = ebase + len;
    $display("test at word %0d: cnt %0d, frame length %0d", base, cnt, len);
    apb_write(`AVG_ADR_CNT, pat[base]);
    apb_write(`AVG_ADR_CTL, 32'h3);  // clr plus run
    if (mid_clear) begin
      send_frames(base + 2, len, len, 1'b0);  // one pass only
      k  = 0;
      rd = '0;
      while (rd[15:0] != 16'd1 && k < TMO) begin
        apb_read(`AVG_ADR_STS, rd);
        k++;
      end
      if (rd[15:0] != 16'd1) begin
        $display("ERROR t=%0t pass count never reached 1 before the clear", $time);
        failures++;
      end
      apb_write(`AVG_ADR_CTL, 32'h3);
      apb_read(`AVG_ADR_STS, rd);
      compare("sts.cnt", 32'd0, {16'd0, rd[15:0]});
    end
    apb_read(`AVG_ADR_STS, seq0);
    compare("sts.seq", 32'd0, {24'd0, seq0[23:16]});  // clr restarts the count
    fork
      send_frames(base + 2, nsmp, len, gaps);
      collect_sums(ebase, len, gaps);
    join
    @(posedge clk);
    #1;
    out_ready = 1'b1;
    repeat (16) begin  // nothing beyond one frame
      @(negedge clk);
      expect_true(!out_valid, "output beat beyond the expected frame");
    end
    apb_read(`AVG_ADR_STS, rd);
    compare("sts.seq", 32'd1, {24'd0, rd[23:16]});
    compare("sts.cnt", 32'd0, {16'd0, rd[15:0]});
    apb_write(`AVG_ADR_CTL, 32'h0);  // stop, window now readable
    for (k = 0; k < len; k++) begin
      apb_read(12'(`AVG_ADR_MEM + 4 * k), rd);
      compare("mem window", pat[ebase + k], rd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic        err;
    int          ptr;
    int          nxt;
    int          t;
    clk       = 1'b0;
    rst       = 1'b1;
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    apb       = '0;
    void'($urandom(32'h3452));
    $readmemh("tests/avg_patterns.txt", pat);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    expect_true(!out_valid, "out_valid high after reset");
    apb_read(`AVG_ADR_STS, rd);
    compare("sts", 32'd0, rd);

    // input FIFO blocks when full and clr flushes it
    fill_input_fifo();
    apb_write(`AVG_ADR_CTL, 32'h2);  // clr only
    apb_read(`AVG_ADR_CTL, rd);
    compare("ctl.run", 32'h0, rd);
    compare("in_ready", 32'd1, {31'd0, in_ready});

    // register access and slave errors
    apb_write(`AVG_ADR_CNT, 32'h0000_1234);
    apb_read(`AVG_ADR_CNT, rd);
    compare("cnt", 32'h0000_1234, rd);
    apb_write(`AVG_ADR_CTL, 32'h1);
    apb_read(`AVG_ADR_CTL, rd);
    compare("ctl.run", 32'h1, rd);
    apb_write(`AVG_ADR_CTL, 32'h0);
    apb_read(`AVG_ADR_CTL, rd);
    compare("ctl.run", 32'h0, rd);
    apb_access(1'b0, 12'h00c, 32'd0, rd, err);
    expect_true(err, "no slave error on a read of unmapped address 0x00c");
    apb_access(1'b1, `AVG_ADR_STS, 32'd0, rd, err);
    expect_true(err, "no slave error on a write to STS");
    apb_access(1'b1, `AVG_ADR_MEM, 32'd0, rd, err);
    expect_true(err, "no slave error on a write to the memory window");

    // tests until a zero frame length, third one gets the mid clear
    ptr = 0;
    t   = 0;
    while (pat[ptr + 1] != 32'd0 && t < 8) begin
      run_test(ptr, t != 0, t == 2, nxt);
      ptr = nxt;
      t++;
    end
    expect_true(t == 3, "pattern file did not hold three tests");

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== hw/avg_top.sv ====
// signal averager, input FIFO -> accumulator -> output FIFO, APB control
// output latency varies with FIFO occupancy, follow out_valid
// frames 4..AVG_AMS samples, host divides the sums
`timescale 1ns/1ns
`include "avg_consts.svh"

module avg_top import avg_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  // input stream
  input  sample_beat_t in_beat,
  input  logic         in_valid,
  output logic         in_ready,
  // output stream
  output sum_beat_t    out_beat,
  output logic         out_valid,
  input  logic         out_ready,
  // host
  input  apb_req_t     apb,
  output apb_rsp_t     rsp
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////////////////////

  sample_beat_t            sti_beat;   // in FIFO -> accumulator
  logic                    sti_valid;
  logic                    sti_ready;
  sum_beat_t               sto_beat;   // accumulator -> out FIFO
  logic                    sto_valid;
  logic [`AVG_FIFO_CW-1:0] out_room;
  avg_cfg_t                cfg;
  avg_sts_t                sts;
  logic                    mem_ren;    // window reads
  logic [`AVG_AAW-1:0]     mem_adr;
  logic [`AVG_ODW-1:0]     mem_rdt;

  avg_stream_fifo #(.payload_t(sample_beat_t)) u_in_fifo (
    .clk        (clk),
    .rst        (rst),
    .clr        (cfg.clr),
    .push_valid (in_valid),
    .push_ready (in_ready),
    .push_data  (in_beat),
    .pop_valid  (sti_valid),
    .pop_ready  (sti_ready),
    .pop_data   (sti_beat),
    .room       ()            // input side needs no room
  );

  avg_accum u_accum (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .sts       (sts),
    .sti_beat  (sti_beat),
    .sti_valid (sti_valid),
    .sti_ready (sti_ready),
    .sto_beat  (sto_beat),
    .sto_valid (sto_valid),
    .out_room  (out_room),
    .bus_ren   (mem_ren),
    .bus_adr   (mem_adr),
    .bus_rdt   (mem_rdt)
  );

  // push_ready unused, the accumulator throttles itself on room
  avg_stream_fifo #(.payload_t(sum_beat_t)) u_out_fifo (
    .clk        (clk),
    .rst        (rst),
    .clr        (cfg.clr),
    .push_valid (sto_valid),
    .push_ready (),
    .push_data  (sto_beat),
    .pop_valid  (out_valid),
    .pop_ready  (out_ready),
    .pop_data   (out_beat),
    .room       (out_room)
  );

  avg_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .apb     (apb),
    .rsp     (rsp),
    .cfg     (cfg),
    .sts     (sts),
    .mem_ren (mem_ren),
    .mem_adr (mem_adr),
    .mem_rdt (mem_rdt)
  );

endmodule

// ==== hw/avg_regs.sv ====
// APB slave for the averager, zero wait states except window reads (one)
// window reads are only meaningful while run is low
// a write with bit 1 of CTL set also loads run from bit 0
`timescale 1ns/1ns
`include "avg_consts.svh"

module avg_regs import avg_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  apb_req_t            apb,
  output apb_rsp_t            rsp,
  output avg_cfg_t            cfg,
  input  avg_sts_t            sts,
  output logic                mem_ren,
  output logic [`AVG_AAW-1:0] mem_adr,
  input  logic [`AVG_ODW-1:0] mem_rdt
);

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  logic        acc;       // access phase
  logic        sel_ctl;
  logic        sel_cnt;
  logic        sel_sts;
  logic        sel_win;   // memory window
  logic        rd_win;    // window read, needs a wait state
  logic        mem_wait;  // second access cycle of a window read
  logic        rdy;
  logic [11:0] win_off;   // byte offset into window
  logic [7:0]  seq_cnt;   // completed sequences

  assign acc     = apb.psel & apb.penable;
  assign sel_ctl = (apb.paddr == `AVG_ADR_CTL);
  assign sel_cnt = (apb.paddr == `AVG_ADR_CNT);
  assign sel_sts = (apb.paddr == `AVG_ADR_STS);
  assign sel_win = (apb.paddr >= `AVG_ADR_MEM) &&
                   (apb.paddr <  `AVG_ADR_MEM + 4 * `AVG_AMS);
  assign rd_win  = sel_win & ~apb.pwrite;

  // window word address
  assign win_off = apb.paddr - `AVG_ADR_MEM;
  assign mem_adr = win_off[`AVG_AAW+1:2];

  // read issued in first access cycle only
  assign mem_ren = acc & rd_win & ~mem_wait;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wait <= 1'b0;
    end else begin
      mem_wait <= mem_ren;  // data lands next cycle
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  assign rdy        = acc & (~rd_win | mem_wait);
  assign rsp.pready = rdy;

  // writes only to CTL/CNT, reads anywhere mapped
  always_comb begin
    if (apb.pwrite) begin
      rsp.pslverr = rdy & ~(sel_ctl | sel_cnt);
    end else begin
      rsp.pslverr = rdy & ~(sel_ctl | sel_cnt | sel_sts | sel_win);
    end
  end

  always_comb begin
    rsp.prdata = '0;  // unmapped reads as zero
    if (sel_ctl) begin
      rsp.prdata[0] = cfg.run;  // clr self clears, reads 0
    end else if (sel_cnt) begin
      rsp.prdata[`AVG_ACW-1:0] = cfg.cnt;
    end else if (sel_sts) begin
      rsp.prdata = {8'h00, seq_cnt, sts.cnt};
    end else if (sel_win) begin
      rsp.prdata = {{(32 - `AVG_ODW){mem_rdt[`AVG_ODW-1]}}, mem_rdt};  // sign extend
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
    end else begin
      cfg.clr <= 1'b0;                   // pulse
      if (acc & apb.pwrite & sel_ctl) begin
        cfg.run <= apb.pwdata[0];
        cfg.clr <= apb.pwdata[1];
      end
      if (acc & apb.pwrite & sel_cnt) begin
        cfg.cnt <= apb.pwdata[`AVG_ACW-1:0];
      end
    end
  end

  // completed sequence count, wraps at 256
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (cfg.clr) begin
      seq_cnt <= '0;
    end else if (sts.seq_end) begin
      seq_cnt <= seq_cnt + 8'd1;
    end
  end

endmodule

// ==== hw/avg_accum.sv ====
// frame accumulator, three stage read-modify-write on the sum memory
// frames must be 4..AVG_AMS samples, shorter ones read stale sums
// output has no hold, input is throttled by the output FIFO room instead
`timescale 1ns/1ns
`include "avg_consts.svh"

module avg_accum import avg_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  avg_cfg_t               cfg,
  output avg_sts_t               sts,
  input  sample_beat_t           sti_beat,
  input  logic                   sti_valid,
  output logic                   sti_ready,
  output sum_beat_t              sto_beat,
  output logic                   sto_valid,  // single cycle, no ready
  input  logic [`AVG_FIFO_CW-1:0] out_room,
  input  logic                   bus_ren,
  input  logic [`AVG_AAW-1:0]    bus_adr,
  output logic [`AVG_ODW-1:0]    bus_rdt
);

  localparam int ROOM_MIN = 4;  // three in flight plus the one accepted

  logic                sti_trnsfr;
  logic [`AVG_ACW-1:0] acu_cnt;     // pass counter
  logic                acu_end;     // on the final pass
  logic [`AVG_AAW-1:0] frm_adr;     // position in frame

  logic [`AVG_ODW-1:0] mem [`AVG_AMS];
  logic                mem_ren;
  logic [`AVG_AAW-1:0] mem_rad;
  logic [`AVG_ODW-1:0] mem_rdt;

  // stage 1, beat and read data
  logic                p1_vld;
  logic                p1_lst;
  logic                p1_beg;      // first pass, add to zero
  logic                p1_fin;      // final pass, emit
  logic [`AVG_IDW-1:0] p1_dat;
  logic [`AVG_AAW-1:0] p1_adr;
  // stage 2, low half sum
  logic                p2_vld;
  logic                p2_lst;
  logic                p2_fin;
  logic                p2_cry;
  logic                p2_sgn;
  logic [`AVG_IDW-1:0] p2_lo;
  logic [`AVG_ACW-1:0] p2_hi;
  logic [`AVG_AAW-1:0] p2_adr;
  // stage 3, full sum, write enable
  logic                p3_vld;
  logic                p3_lst;
  logic                p3_fin;
  logic [`AVG_ODW-1:0] p3_sum;
  logic [`AVG_AAW-1:0] p3_adr;

  ////////////////////////////////////////////////////////////////////////////
  // stream side, counters
  ////////////////////////////////////////////////////////////////////////////

  assign sti_ready  = cfg.run & (out_room >= `AVG_FIFO_CW'(ROOM_MIN));
  assign sti_trnsfr = sti_valid & sti_ready;
  assign acu_end    = (acu_cnt == cfg.cnt);

  always_ff @(posedge clk) begin
    if (rst | cfg.clr) begin
      acu_cnt <= '0;
      frm_adr <= '0;
    end else if (sti_trnsfr) begin
      frm_adr <= sti_beat.last ? '0 : frm_adr + 1'b1;  // restart on last
      if (sti_beat.last) begin
        acu_cnt <= acu_end ? '0 : acu_cnt + 1'b1;  // wrap after cfg.cnt
      end
    end
  end

  assign sts.cnt     = acu_cnt;
  assign sts.seq_end = sti_trnsfr & sti_beat.last & acu_end;

  ////////////////////////////////////////////////////////////////////////////
  // memory, read port shared with the bus while stopped
  ////////////////////////////////////////////////////////////////////////////

  assign mem_ren = cfg.run ? sti_trnsfr : bus_ren;
  assign mem_rad = cfg.run ? frm_adr    : bus_adr;
  assign bus_rdt = mem_rdt;

  always_ff @(posedge clk) begin
    if (mem_ren) begin
      mem_rdt <= mem[mem_rad];
    end
    if (p3_vld) begin
      mem[p3_adr] <= p3_sum;  // t+3
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | cfg.clr) begin
      p1_vld <= 1'b0;
      p2_vld <= 1'b0;
      p3_vld <= 1'b0;
    end else begin
      p1_vld <= sti_trnsfr;
      p2_vld <= p1_vld;
      p3_vld <= p2_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trnsfr) begin            // t, read issued alongside
      p1_lst <= sti_beat.last;
      p1_dat <= sti_beat.data;
      p1_adr <= frm_adr;
      p1_beg <= (acu_cnt == '0);
      p1_fin <= acu_end;
    end
    if (p1_vld) begin                // t+1, low part plus carry out
      {p2_cry, p2_lo} <= {1'b0, p1_beg ? '0 : mem_rdt[`AVG_IDW-1:0]} + {1'b0, p1_dat};
      p2_hi  <= p1_beg ? '0 : mem_rdt[`AVG_ODW-1:`AVG_IDW];
      p2_sgn <= p1_dat[`AVG_IDW-1];
      p2_lst <= p1_lst;
      p2_fin <= p1_fin;
      p2_adr <= p1_adr;
    end
    if (p2_vld) begin                // t+2, upper part gets sign and carry
      p3_sum[`AVG_IDW-1:0]        <= p2_lo;
      p3_sum[`AVG_ODW-1:`AVG_IDW] <= p2_hi + {`AVG_ACW{p2_sgn}} + `AVG_ACW'(p2_cry);
      p3_lst <= p2_lst;
      p3_fin <= p2_fin;
      p3_adr <= p2_adr;
    end
  end

  // emit only on the final pass, same cycle as the write
  assign sto_valid     = p3_vld & p3_fin;
  assign sto_beat.last = p3_lst;
  assign sto_beat.data = p3_sum;

endmodule

// ==== hw/avg_stream_fifo.sv ====
// register array FIFO, AVG_FIFO_DEPTH entries (power of two)
// no bypass, a push shows at the output one cycle later
`timescale 1ns/1ns
`include "avg_consts.svh"

module avg_stream_fifo import avg_pkg::*; #(
  parameter type payload_t = sample_beat_t
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clr,         // flush
  input  logic                    push_valid,
  output logic                    push_ready,
  input  payload_t                push_data,
  output logic                    pop_valid,
  input  logic                    pop_ready,
  output payload_t                pop_data,
  output logic [`AVG_FIFO_CW-1:0] room         // free entries
);

  localparam int DEPTH = `AVG_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  payload_t                buf_q [DEPTH];
  logic [PW-1:0]           wr_ptr;
  logic [PW-1:0]           rd_ptr;
  logic [`AVG_FIFO_CW-1:0] count;
  logic                    push;
  logic                    pop;

  assign push_ready = (count != `AVG_FIFO_CW'(DEPTH));  // full blocks push
  assign pop_valid  = (count != '0);
  assign pop_data   = buf_q[rd_ptr];
  assign room       = `AVG_FIFO_CW'(DEPTH) - count;

  assign push = push_valid & push_ready;
  assign pop  = pop_valid & pop_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst | clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // idle or both
      endcase
    end
  end

endmodule

// ==== hw/avg_pkg.sv ====
// stream, APB and control types shared by the averager blocks
// widths come from avg_consts.svh
`include "avg_consts.svh"

package avg_pkg;

  // input stream beat, 15 bits
  typedef struct packed {
    logic                       last;  // final sample of frame
    logic signed [`AVG_IDW-1:0] data;
  } sample_beat_t;

  // output stream beat, 31 bits
  typedef struct packed {
    logic                       last;  // repeats the frame's last flag
    logic signed [`AVG_ODW-1:0] data;  // accumulated sum
  } sum_beat_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;  // only meaningful with pready
  } apb_rsp_t;

  // register block -> accumulator
  typedef struct packed {
    logic                run;
    logic                clr;  // single cycle
    logic [`AVG_ACW-1:0] cnt;  // index of the last pass
  } avg_cfg_t;

  // accumulator -> register block
  typedef struct packed {
    logic [`AVG_ACW-1:0] cnt;      // current pass
    logic                seq_end;  // single cycle, final beat of final pass
  } avg_sts_t;

endpackage

// ==== hw/avg_consts.svh ====
// widths, memory size and APB map of the signal averager
// AVG_FIFO_DEPTH must be a power of two, AVG_AMS must equal 2**AVG_AAW
`ifndef AVG_CONSTS_SVH
`define AVG_CONSTS_SVH

`define AVG_IDW        14                    // input sample width
`define AVG_ACW        16                    // pass counter width
`define AVG_ODW        (`AVG_IDW + `AVG_ACW) // sum width, 30
`define AVG_AMS        64                    // sum memory words
`define AVG_AAW        6                     // sum memory address width

`define AVG_FIFO_DEPTH 8                     // entries per stream FIFO
`define AVG_FIFO_CW    $clog2(`AVG_FIFO_DEPTH + 1)  // occupancy / room width

// APB map, byte addresses
`define AVG_ADR_CTL    12'h000
`define AVG_ADR_CNT    12'h004
`define AVG_ADR_STS    12'h008
`define AVG_ADR_MEM    12'h100               // memory window, one word per position

`endif
